//--- rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // ********************************************************************
  // Bus request and response
  // ********************************************************************

  typedef struct packed {
    logic valid;
    logic instr;               // Fetch flag from the core
    logic [31 : 0] addr;
    logic [31 : 0] wdata;
    logic [3 : 0] wstrb;       // All zero marks a read
  } mem_req_t;

  typedef struct packed {
    logic [31 : 0] rdata;
    logic ready;               // One cycle pulse per access
  } mem_rsp_t;

  // ********************************************************************
  // Address map
  // ********************************************************************

  // Half open window, everything outside it lands in the RAM
  localparam logic [31 : 0] timer_base_addr = 32'h0200_0000;
  localparam logic [31 : 0] timer_top_addr = 32'h0200_0010;

  localparam logic [3 : 0] timer_mtime_lo = 4'h0;
  localparam logic [3 : 0] timer_mtime_hi = 4'h4;
  localparam logic [3 : 0] timer_mtimecmp_lo = 4'h8;
  localparam logic [3 : 0] timer_mtimecmp_hi = 4'hC;

  // ********************************************************************
  // Memory and timer sizing
  // ********************************************************************

  localparam int bram_depth = 1024;                    // Words
  localparam int bram_addr_bits = $clog2(bram_depth);  // Word index width

  // Clocks per half period of rtc
  localparam logic [15 : 0] clk_divider_rtc = 16'd4;

endpackage

`default_nettype wire

//--- rtl/bus_router.sv
`default_nettype none

module bus_router (
  input soc_pkg::mem_req_t mem_req,
  output soc_pkg::mem_rsp_t mem_rsp,
  output soc_pkg::mem_req_t ram_req,
  output soc_pkg::mem_req_t tmr_req,
  input soc_pkg::mem_rsp_t ram_rsp,
  input soc_pkg::mem_rsp_t tmr_rsp
);
  import soc_pkg::*;

  logic in_timer;

  // ********************************************************************
  // Address decode
  // ********************************************************************

  always_comb begin
    in_timer = (mem_req.addr >= timer_base_addr) &&
               (mem_req.addr < timer_top_addr);
  end

  // Payload goes to both slaves, only the selected one sees valid
  always_comb begin
    ram_req = mem_req;
    tmr_req = mem_req;

    if (in_timer) begin
      ram_req.valid = 1'b0;
      tmr_req.valid = mem_req.valid;
    end else begin
      ram_req.valid = mem_req.valid;  // Default target, address wraps there
      tmr_req.valid = 1'b0;
    end
  end

  // ********************************************************************
  // Response merge
  // ********************************************************************

  always_comb begin
    if (ram_rsp.ready == 1'b1) begin
      mem_rsp.rdata = ram_rsp.rdata;
      mem_rsp.ready = ram_rsp.ready;
    end else if (tmr_rsp.ready == 1'b1) begin
      mem_rsp.rdata = tmr_rsp.rdata;
      mem_rsp.ready = tmr_rsp.ready;
    end else begin
      mem_rsp.rdata = '0;  // Idle bus reads as zero
      mem_rsp.ready = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/block_ram.sv
`default_nettype none

module block_ram (
  input logic clk,
  input logic rst,
  input soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);
  import soc_pkg::*;

  logic [31 : 0] mem [bram_depth];
  logic [bram_addr_bits - 1 : 0] idx;
  logic access;
  logic [31 : 0] rdata_q;
  logic ready_q;

  // ********************************************************************
  // Access control
  // ********************************************************************

  // Upper address bits are dropped so the RAM repeats across the map
  assign idx = req.addr[bram_addr_bits + 1 : 2];

  // Only the first valid cycle counts, the ready cycle is ignored
  assign access = req.valid && !ready_q;

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  // ********************************************************************
  // Storage
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= mem[idx];  // Old word, before this access writes it
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[idx][8 * i +: 8] <= req.wdata[8 * i +: 8];
        end
      end
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

//--- rtl/machine_timer.sv
`default_nettype none

module machine_timer (
  input logic clk,
  input logic rst,
  input soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic irpt
);
  import soc_pkg::*;

  logic [15 : 0] count;
  logic rtc;
  logic rtc_q;
  logic rtc_rise;

  logic [63 : 0] mtime;
  logic [63 : 0] mtime_inc;
  logic [63 : 0] mtimecmp;

  logic access;
  logic write;
  logic [31 : 0] rdata_next;
  logic [31 : 0] rdata_q;
  logic ready_q;

  // ********************************************************************
  // Real time clock
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      count <= '0;
      rtc <= 1'b0;
      rtc_q <= 1'b0;
    end else begin
      rtc_q <= rtc;
      if (count == clk_divider_rtc - 16'd1) begin
        rtc <= ~rtc;
        count <= '0;
      end else begin
        count <= count + 16'd1;
      end
    end
  end

  assign rtc_rise = rtc && !rtc_q;  // One tick per full rtc period
  assign mtime_inc = rtc_rise ? mtime + 64'd1 : mtime;

  // ********************************************************************
  // Register interface
  // ********************************************************************

  assign access = req.valid && !ready_q;
  assign write = access && (req.wstrb != 4'b0000);  // Any strobe means a full word

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      mtime <= '0;
      mtimecmp <= '1;  // Far future, interrupt stays low
    end else begin
      mtime <= mtime_inc;
      if (write) begin
        case (req.addr[3 : 0])
          timer_mtime_lo: mtime <= {mtime_inc[63 : 32], req.wdata};
          timer_mtime_hi: mtime <= {req.wdata, mtime_inc[31 : 0]};
          timer_mtimecmp_lo: mtimecmp[31 : 0] <= req.wdata;
          timer_mtimecmp_hi: mtimecmp[63 : 32] <= req.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (req.addr[3 : 0])
      timer_mtime_lo: rdata_next = mtime[31 : 0];
      timer_mtime_hi: rdata_next = mtime[63 : 32];
      timer_mtimecmp_lo: rdata_next = mtimecmp[31 : 0];
      timer_mtimecmp_hi: rdata_next = mtimecmp[63 : 32];
      default: rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rdata_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      ready_q <= 1'b0;
      irpt <= 1'b0;
    end else begin
      ready_q <= access;
      irpt <= (mtime >= mtimecmp);  // Lags the registers by one clock
    end
  end

  assign rsp = '{rdata: rdata_q, ready: ready_q};

endmodule

`default_nettype wire

//--- rtl/soc_top.sv
`default_nettype none

module soc_top (
  input logic clk,
  input logic rst,
  input soc_pkg::mem_req_t mem_req,
  output soc_pkg::mem_rsp_t mem_rsp,
  output logic timer_irpt
);
  import soc_pkg::*;

  mem_req_t ram_req;
  mem_req_t tmr_req;
  mem_rsp_t ram_rsp;
  mem_rsp_t tmr_rsp;

  // ********************************************************************
  // Interconnect and slaves
  // ********************************************************************

  bus_router router_i (
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .ram_req (ram_req),
    .tmr_req (tmr_req),
    .ram_rsp (ram_rsp),
    .tmr_rsp (tmr_rsp)
  );

  block_ram ram_i (
    .clk (clk),
    .rst (rst),
    .req (ram_req),
    .rsp (ram_rsp)
  );

  machine_timer timer_i (
    .clk (clk),
    .rst (rst),
    .req (tmr_req),
    .rsp (tmr_rsp),
    .irpt (timer_irpt)  // Goes straight to the core
  );

endmodule

`default_nettype wire

//--- tb/soc_tb_table.svh
`ifndef soc_tb_table_svh
`define soc_tb_table_svh

// Columns of add_entry are op, addr, wdata, wstrb, expected value
function automatic void load_table();
  logic [31 : 0] rtc_wait;
  rtc_wait = {16'h0, clk_divider_rtc} * 32'd10;  // Five mtime ticks

  // ********************************************************************
  // Timer state after reset and counting
  // ********************************************************************
  add_entry(op_read, tmr_addr(timer_mtimecmp_hi), '0, 4'h0, 32'hFFFF_FFFF);
  add_entry(op_read, tmr_addr(timer_mtimecmp_lo), '0, 4'h0, 32'hFFFF_FFFF);
  add_entry(op_irpt, '0, 32'd0, 4'h0, 32'd0);
  add_entry(op_sample, tmr_addr(timer_mtime_lo), '0, 4'h0, '0);
  add_entry(op_idle, '0, rtc_wait, 4'h0, '0);
  add_entry(op_read_gt, tmr_addr(timer_mtime_lo), '0, 4'h0, '0);

  // ********************************************************************
  // Interrupt on compare
  // ********************************************************************
  add_entry(op_write, tmr_addr(timer_mtimecmp_lo), 32'h0, 4'hF, '0);
  add_entry(op_irpt, '0, 32'd0, 4'h0, 32'd0);  // Upper half still far away
  add_entry(op_write, tmr_addr(timer_mtimecmp_hi), 32'h0, 4'hF, '0);
  add_entry(op_irpt, '0, 32'd1, 4'h0, 32'd1);
  add_entry(op_read, tmr_addr(timer_mtimecmp_hi), '0, 4'h0, 32'h0);
  add_entry(op_write, tmr_addr(timer_mtimecmp_hi), 32'hFFFF_FFFF, 4'hF, '0);
  add_entry(op_irpt, '0, 32'd1, 4'h0, 32'd0);

  // ********************************************************************
  // Writes to mtime
  // ********************************************************************
  add_entry(op_write, tmr_addr(timer_mtime_hi), 32'h0000_00A5, 4'hF, '0);
  add_entry(op_read, tmr_addr(timer_mtime_hi), '0, 4'h0, 32'h0000_00A5);
  add_entry(op_irpt, '0, 32'd1, 4'h0, 32'd0);
  add_entry(op_write, tmr_addr(timer_mtime_hi), 32'hFFFF_FFFF, 4'hF, '0);
  add_entry(op_read, tmr_addr(timer_mtime_hi), '0, 4'h0, 32'hFFFF_FFFF);
  add_entry(op_irpt, '0, 32'd1, 4'h0, 32'd1);  // mtime now passes mtimecmp
  add_entry(op_write, tmr_addr(timer_mtime_hi), 32'h0, 4'hF, '0);
  add_entry(op_irpt, '0, 32'd1, 4'h0, 32'd0);

  // ********************************************************************
  // RAM byte strobes
  // ********************************************************************
  add_entry(op_write, 32'h0000_0100, 32'h1122_3344, 4'hF, '0);
  add_entry(op_read, 32'h0000_0100, '0, 4'h0, 32'h1122_3344);
  add_entry(op_write, 32'h0000_0100, 32'hAAAA_AAAA, 4'b0001, '0);
  add_entry(op_read, 32'h0000_0100, '0, 4'h0, 32'h1122_33AA);
  add_entry(op_write, 32'h0000_0100, 32'hBBBB_BBBB, 4'b0010, '0);
  add_entry(op_read, 32'h0000_0100, '0, 4'h0, 32'h1122_BBAA);
  add_entry(op_write, 32'h0000_0100, 32'hCCCC_CCCC, 4'b0100, '0);
  add_entry(op_read, 32'h0000_0100, '0, 4'h0, 32'h11CC_BBAA);
  add_entry(op_write, 32'h0000_0100, 32'hDDDD_DDDD, 4'b1000, '0);
  add_entry(op_read, 32'h0000_0100, '0, 4'h0, 32'hDDCC_BBAA);

  // ********************************************************************
  // Address wrap and default routing
  // ********************************************************************
  add_entry(op_write, 32'h0010_0040, 32'hCAFE_F00D, 4'hF, '0);
  add_entry(op_read, 32'h0000_0040, '0, 4'h0, 32'hCAFE_F00D);
  add_entry(op_read, 32'h0300_0040, '0, 4'h0, 32'hCAFE_F00D);
  add_entry(op_write, timer_top_addr, 32'h0BAD_C0DE, 4'hF, '0);  // First byte past timer
  add_entry(op_read, 32'h0000_0010, '0, 4'h0, 32'h0BAD_C0DE);
  add_entry(op_write, timer_base_addr - 32'd4, 32'h5A5A_1234, 4'hF, '0);
  add_entry(op_read, 32'h0000_0FFC, '0, 4'h0, 32'h5A5A_1234);
endfunction

`endif

//--- tb/soc_tb.sv
`default_nettype none

module soc_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import soc_pkg::*;

  localparam int bus_timeout = 20;  // Cycles a slave may take to answer
  localparam int random_count = 16;
  localparam logic [31 : 0] lcg_seed = 32'd58321;

  typedef enum logic [2 : 0] {
    op_write,
    op_read,
    op_sample,   // Read and keep the value for a later op_read_gt
    op_read_gt,
    op_irpt,     // wdata holds the cycles allowed, exp bit 0 the level
    op_idle      // wdata holds the cycle count
  } op_e;

  typedef struct packed {
    op_e op;
    logic [31 : 0] addr;
    logic [31 : 0] wdata;
    logic [3 : 0] wstrb;
    logic [31 : 0] exp;
  } entry_t;

  logic clk;
  logic rst;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  logic timer_irpt;

  entry_t test_table [$];
  logic [31 : 0] model [bram_depth];  // Expected RAM contents for the random pass
  logic [31 : 0] sample_q;
  logic [31 : 0] lcg_state;
  int pass_count;
  int fail_count;

  soc_top dut_i (
    .clk (clk),
    .rst (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .timer_irpt (timer_irpt)
  );

  // ********************************************************************
  // Clock, random numbers and table building
  // ********************************************************************

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31 : 0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31 : 0] tmr_addr(input logic [3 : 0] offset);
    return timer_base_addr | {28'h0, offset};
  endfunction

  function automatic void add_entry(input op_e op, input logic [31 : 0] addr,
                                    input logic [31 : 0] wdata, input logic [3 : 0] wstrb,
                                    input logic [31 : 0] exp);
    entry_t e;
    e = '{op, addr, wdata, wstrb, exp};
    test_table.push_back(e);
  endfunction

  // ********************************************************************
  // Bus master and compare tasks
  // ********************************************************************

  // Called 1 ns after a rising edge, returns at the same point of a later cycle
  task automatic bus_access(input logic [31 : 0] addr, input logic [31 : 0] wdata,
                            input logic [3 : 0] wstrb, output mem_rsp_t rsp, output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    rsp = '0;
    mem_req.valid = 1'b1;
    mem_req.instr = 1'b0;
    mem_req.addr = addr;
    mem_req.wdata = wdata;
    mem_req.wstrb = wstrb;
    while (!ok && cycles < bus_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
      if (mem_rsp.ready == 1'b1) begin
        ok = 1'b1;
        rsp = mem_rsp;
      end
    end
    mem_req = '0;
    if (!ok) begin
      $display("Bus timeout at %0d ns: the slave never answered the access to 0x%08h",
               $time, addr);
      fail_count++;
    end
    @(posedge clk);  // Valid stays low for one full cycle
    #1;
  endtask

  task automatic check_rsp(input string label, input mem_rsp_t got, input mem_rsp_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s returned 0x%08h ready %b, expected 0x%08h ready %b",
               $time, label, got.rdata, got.ready, exp.rdata, exp.ready);
      fail_count++;
    end else begin
      $display("PASS  %s returned 0x%08h", label, got.rdata);
      pass_count++;
    end
  endtask

  task automatic check_irpt(input string label, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, label, got, exp);
      fail_count++;
    end else begin
      $display("PASS  %s is %b", label, got);
      pass_count++;
    end
  endtask

  task automatic check_increase(input string label, input mem_rsp_t got,
                                input logic [31 : 0] prev);
    if (got.ready !== 1'b1 || (got.rdata > prev) !== 1'b1) begin
      $display("ERROR at %0d ns: %s returned 0x%08h, expected more than 0x%08h",
               $time, label, got.rdata, prev);
      fail_count++;
    end else begin
      $display("PASS  %s advanced from 0x%08h to 0x%08h", label, prev, got.rdata);
      pass_count++;
    end
  endtask

  task automatic wait_irpt(input int idx, input logic exp, input int limit);
    int cycles;
    cycles = 0;
    while (timer_irpt !== exp && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    check_irpt($sformatf("entry %0d timer_irpt after %0d cycles", idx, cycles),
               timer_irpt, exp);
  endtask

  // ********************************************************************
  // Test sequences
  // ********************************************************************

  task automatic run_entry(input int idx, input entry_t e);
    mem_rsp_t rsp;
    mem_rsp_t exp;
    bit ok;
    exp.rdata = e.exp;
    exp.ready = 1'b1;
    case (e.op)
      op_write: begin
        bus_access(e.addr, e.wdata, e.wstrb, rsp, ok);
        if (ok) begin
          $display("done  entry %0d write 0x%08h to 0x%08h strobe %b",
                   idx, e.wdata, e.addr, e.wstrb);
        end
      end
      op_read: begin
        bus_access(e.addr, '0, 4'h0, rsp, ok);
        if (ok) begin
          check_rsp($sformatf("entry %0d read 0x%08h", idx, e.addr), rsp, exp);
        end
      end
      op_sample: begin
        bus_access(e.addr, '0, 4'h0, rsp, ok);
        sample_q = rsp.rdata;
        if (ok) begin
          $display("done  entry %0d sampled 0x%08h from 0x%08h", idx, rsp.rdata, e.addr);
        end
      end
      op_read_gt: begin
        bus_access(e.addr, '0, 4'h0, rsp, ok);
        if (ok) begin
          check_increase($sformatf("entry %0d read 0x%08h", idx, e.addr), rsp, sample_q);
        end
      end
      op_irpt: begin
        wait_irpt(idx, e.exp[0], int'(e.wdata));
      end
      op_idle: begin
        repeat (e.wdata) begin
          @(posedge clk);
          #1;
        end
      end
      default: ;
    endcase
  endtask

  task automatic random_round_trip();
    logic [31 : 0] addrs [random_count];
    logic [31 : 0] rnd;
    logic [31 : 0] data;
    mem_rsp_t rsp;
    mem_rsp_t exp;
    bit ok;
    for (int i = 0; i < random_count; i++) begin
      rnd = lcg_next();
      addrs[i] = {20'h0, rnd[21 : 12], 2'b00};  // Upper LCG bits are the better ones
      data = lcg_next();
      model[addrs[i][bram_addr_bits + 1 : 2]] = data;
      bus_access(addrs[i], data, 4'hF, rsp, ok);
    end
    for (int i = 0; i < random_count; i++) begin
      bus_access(addrs[i], '0, 4'h0, rsp, ok);
      exp.rdata = model[addrs[i][bram_addr_bits + 1 : 2]];
      exp.ready = 1'b1;
      if (ok) begin
        check_rsp($sformatf("random read %0d at 0x%08h", i, addrs[i]), rsp, exp);
      end
    end
  endtask

  initial begin
    rst = 1'b0;
    mem_req = '0;
    pass_count = 0;
    fail_count = 0;
    sample_q = '0;
    lcg_state = lcg_seed;
    load_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < test_table.size(); i++) begin
      run_entry(i, test_table[i]);
    end
    random_round_trip();
    $display("Checks finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  `include "soc_tb_table.svh"

endmodule

`default_nettype wire

//--- soc.f
+incdir+tb
rtl/soc_pkg.sv
rtl/bus_router.sv
rtl/block_ram.sv
rtl/machine_timer.sv
rtl/soc_top.sv
tb/soc_tb.sv

//--- Makefile
# Verilator flow for the SoC memory bus testbench

VERILATOR ?= verilator
TOP ?= soc_tb
FILELIST ?= soc.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= Verification passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the simulator output
run: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
